/* bench/switch_core_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module switch_core_checker (
    input wire logic                             clk,
    input wire logic                             rst_n,
    input wire logic                             hdr_valid_i,
    input wire logic [switch_pkg::PORT_W-1:0]    hdr_port_i,
    input wire logic                             fwd_valid_o,
    input wire logic [switch_pkg::NUM_PORTS-1:0] fwd_mask_o
);

    import switch_pkg::*;

    int failures = 0;

    // Every result belongs to a header two edges back, and the reverse.
    assert property (@(posedge clk) disable iff (!rst_n)
        fwd_valid_o == $past(hdr_valid_i, 2))
    else begin
        failures++;
        $error("fwd_valid_o does not follow hdr_valid_i by two cycles");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        fwd_valid_o |-> !fwd_mask_o[$past(hdr_port_i, 2)])
    else begin
        failures++;
        $error("fwd_mask_o contains the ingress port");
    end

    assert property (@(posedge clk) !rst_n |-> (!fwd_valid_o && fwd_mask_o == '0))
    else begin
        failures++;
        $error("Forwarding outputs active during reset");
    end

endmodule

`default_nettype wire

/* bench/tb_switch_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_switch_core;

    import switch_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 5;
    localparam logic [31:0] SEED = 32'd834;
    localparam int RANDOM_HEADERS = 100;
    localparam int TOTAL_HEADERS = 19 + 2 * RANDOM_HEADERS;
    // Three cycles a header, plus reset, register access and drain for six tests.
    localparam int WATCHDOG_CYCLES = 3 * TOTAL_HEADERS + 6 * 60;

    localparam logic [MAC_W-1:0] MAC_A = 48'h02_00_00_00_00_0A;
    localparam logic [MAC_W-1:0] MAC_B = 48'h02_00_00_00_00_0B;
    localparam logic [MAC_W-1:0] MAC_C = 48'h02_00_00_00_00_0C;
    localparam logic [MAC_W-1:0] MAC_D = 48'h02_00_00_00_00_0D;
    localparam logic [MAC_W-1:0] MAC_E = 48'h02_00_00_00_00_0E;
    localparam logic [MAC_W-1:0] MAC_F = 48'h02_00_00_00_00_0F;
    localparam logic [MAC_W-1:0] MAC_X = 48'h02_00_00_00_00_99;
    localparam logic [MAC_W-1:0] MAC_GROUP = 48'h01_00_5E_00_00_01;
    localparam logic [MAC_W-1:0] MAC_BCAST = 48'hFF_FF_FF_FF_FF_FF;

    logic clk = 1'b0;
    logic rst_n;
    logic hdr_valid_i;
    logic [PORT_W-1:0] hdr_port_i;
    logic [MAC_W-1:0] hdr_src_i;
    logic [MAC_W-1:0] hdr_dst_i;
    logic cfg_we_i;
    logic [CFG_ADDR_W-1:0] cfg_addr_i;
    logic [CFG_DATA_W-1:0] cfg_wdata_i;
    logic [CFG_DATA_W-1:0] cfg_rdata_o;
    logic fwd_valid_o;
    logic [NUM_PORTS-1:0] fwd_mask_o;

    logic [NUM_PORTS-1:0] expected_q [$];
    logic [MAC_W-1:0] model_mac [NUM_ENTRIES];
    logic [PORT_W-1:0] model_port [NUM_ENTRIES];
    int model_count;
    logic [NUM_PORTS-1:0] model_port_en;
    logic model_learn_en;
    int model_hits;
    int model_floods;
    logic [31:0] rng_state = SEED;
    int mask_errors = 0;
    int count_errors = 0;
    int reg_errors = 0;
    int other_errors = 0;

    switch_core uut (.*);

    bind switch_core switch_core_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .hdr_valid_i (hdr_valid_i),
        .hdr_port_i  (hdr_port_i),
        .fwd_valid_o (fwd_valid_o),
        .fwd_mask_o  (fwd_mask_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_mask(input logic [NUM_PORTS-1:0] got, input logic [NUM_PORTS-1:0] exp);
        if (got !== exp) begin
            mask_errors++;
            $display("ERROR at %0t: fwd_mask_o is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic compare_count(input string name, input logic [CFG_DATA_W-1:0] got,
                                 input logic [CFG_DATA_W-1:0] exp);
        if (got !== exp) begin
            count_errors++;
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_readback(input string name, input logic [CFG_DATA_W-1:0] got,
                                    input logic [CFG_DATA_W-1:0] exp);
        if (got !== exp) begin
            reg_errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Results are sampled half a cycle after the edge that registers them.
    always @(negedge clk) begin
        if (rst_n && fwd_valid_o) begin
            if (expected_q.size() == 0) begin
                other_errors++;
                $display("Forwarding result at %0t with no header outstanding", $time);
            end else begin
                compare_mask(fwd_mask_o, expected_q.pop_front());
            end
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [MAC_W-1:0] random_mac();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi[15:0], lo};
    endfunction

    function automatic int model_find(input logic [MAC_W-1:0] mac);
        for (int i = 0; i < model_count; i++) begin
            if (model_mac[i] == mac) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Expected mask from learns of earlier headers only.
    function automatic logic [NUM_PORTS-1:0] predict(input logic [PORT_W-1:0] port,
                                                     input logic [MAC_W-1:0] dst);
        int idx;
        logic [NUM_PORTS-1:0] ingress;
        logic [NUM_PORTS-1:0] egress;
        ingress = '0;
        egress = '0;
        ingress[port] = 1'b1;
        if (!model_port_en[port]) begin
            return '0;
        end
        idx = model_find(dst);
        if (idx >= 0 && !dst[MAC_GROUP_BIT]) begin
            model_hits++;
            egress[model_port[idx]] = 1'b1;
            return egress & model_port_en & ~ingress;
        end
        model_floods++;
        return model_port_en & ~ingress;
    endfunction

    task automatic send(input logic [PORT_W-1:0] port, input logic [MAC_W-1:0] src,
                        input logic [MAC_W-1:0] dst, input logic [NUM_PORTS-1:0] exp);
        int idx;
        @(negedge clk);
        hdr_valid_i = 1'b1;
        hdr_port_i = port;
        hdr_src_i = src;
        hdr_dst_i = dst;
        expected_q.push_back(exp);
        if (model_learn_en && model_port_en[port] && !src[MAC_GROUP_BIT]) begin
            idx = model_find(src);
            if (idx < 0) begin
                model_mac[model_count] = src;
                model_port[model_count] = port;
                model_count++;
            end else begin
                model_port[idx] = port;
            end
        end
    endtask

    task automatic drain();
        @(negedge clk);
        hdr_valid_i = 1'b0;
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        // Counters step one edge after the last pulse.
        @(negedge clk);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        hdr_valid_i = 1'b0;
        cfg_we_i = 1'b0;
        expected_q.delete();
        model_count = 0;
        model_port_en = '1;
        model_learn_en = 1'b1;
        model_hits = 0;
        model_floods = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic write_reg(input logic [CFG_ADDR_W-1:0] addr, input logic [CFG_DATA_W-1:0] data);
        @(negedge clk);
        cfg_we_i = 1'b1;
        cfg_addr_i = addr;
        cfg_wdata_i = data;
        @(negedge clk);
        cfg_we_i = 1'b0;
        if (addr == REG_PORT_EN) begin
            model_port_en = data[NUM_PORTS-1:0];
        end
        if (addr == REG_LEARN_EN) begin
            model_learn_en = data[0];
        end
    endtask

    task automatic read_reg(input logic [CFG_ADDR_W-1:0] addr, output logic [CFG_DATA_W-1:0] data);
        @(negedge clk);
        cfg_addr_i = addr;
        #(CLK_PERIOD / 4);
        data = cfg_rdata_o;
    endtask

    task automatic check_counters(input int hits, input int floods);
        logic [CFG_DATA_W-1:0] data;
        read_reg(REG_HIT_CNT, data);
        compare_count("hit_cnt", data, CFG_DATA_W'(hits));
        read_reg(REG_FLOOD_CNT, data);
        compare_count("flood_cnt", data, CFG_DATA_W'(floods));
    endtask

    task automatic test_reset_defaults();
        logic [CFG_DATA_W-1:0] data;
        apply_reset();
        read_reg(REG_PORT_EN, data);
        compare_readback("port_en", data, 32'h0000_000F);
        read_reg(REG_LEARN_EN, data);
        compare_readback("learn_en", data, 32'h0000_0001);
        check_counters(0, 0);
        write_reg(REG_PORT_EN, 32'h0000_0005);
        read_reg(REG_PORT_EN, data);
        compare_readback("port_en", data, 32'h0000_0005);
        write_reg(REG_LEARN_EN, 32'h0000_0000);
        read_reg(REG_LEARN_EN, data);
        compare_readback("learn_en", data, 32'h0000_0000);
        // Upper bits are not stored.
        write_reg(REG_PORT_EN, 32'hFFFF_FFFA);
        read_reg(REG_PORT_EN, data);
        compare_readback("port_en", data, 32'h0000_000A);
    endtask

    task automatic test_flood();
        apply_reset();
        send(2'd0, MAC_A, MAC_B, 4'b1110);
        send(2'd2, MAC_C, MAC_GROUP, 4'b1011);
        send(2'd1, MAC_D, MAC_BCAST, 4'b1101);
        drain();
        check_counters(0, 3);
    endtask

    task automatic test_learn_hit();
        apply_reset();
        send(2'd1, MAC_A, MAC_B, 4'b1101);
        send(2'd3, MAC_C, MAC_A, 4'b0010);
        send(2'd1, MAC_D, MAC_A, 4'b0000);
        drain();
        check_counters(2, 1);
    endtask

    task automatic test_station_move();
        apply_reset();
        send(2'd0, MAC_A, MAC_B, 4'b1110);
        send(2'd2, MAC_C, MAC_A, 4'b0001);
        send(2'd3, MAC_A, MAC_B, 4'b0111);
        send(2'd1, MAC_D, MAC_A, 4'b1000);
        // Own source is not visible to the same header.
        send(2'd2, MAC_E, MAC_E, 4'b1011);
        send(2'd0, MAC_B, MAC_E, 4'b0100);
        drain();
        check_counters(3, 3);
    endtask

    task automatic test_disabled_ports();
        apply_reset();
        send(2'd2, MAC_C, MAC_B, 4'b1011);
        drain();
        write_reg(REG_PORT_EN, 32'h0000_000B);
        send(2'd2, MAC_A, MAC_B, 4'b0000);
        send(2'd0, MAC_B, MAC_A, 4'b1010);
        send(2'd1, MAC_D, MAC_C, 4'b0000);
        send(2'd3, MAC_E, MAC_B, 4'b0001);
        drain();
        write_reg(REG_PORT_EN, 32'h0000_000F);
        write_reg(REG_LEARN_EN, 32'h0000_0000);
        send(2'd1, MAC_F, MAC_X, 4'b1101);
        send(2'd3, MAC_A, MAC_F, 4'b0111);
        drain();
        check_counters(2, 4);
    endtask

    task automatic test_random_stream();
        logic [MAC_W-1:0] pool [6];
        logic [MAC_W-1:0] src;
        logic [MAC_W-1:0] dst;
        logic [31:0] r;
        apply_reset();
        for (int i = 0; i < 6; i++) begin
            pool[i] = random_mac();
            pool[i][MAC_GROUP_BIT] = 1'b0;
        end
        for (int pass = 0; pass < 2; pass++) begin
            if (pass == 1) begin
                r = next_random();
                write_reg(REG_PORT_EN, r & 32'h0000_000F);
            end
            for (int n = 0; n < RANDOM_HEADERS; n++) begin
                r = next_random();
                src = pool[r[2:0] % 3'd6];
                dst = (r[9:8] == 2'd0) ? random_mac() : pool[r[6:4] % 3'd6];
                if (r[11:10] == 2'd0) begin
                    src[MAC_GROUP_BIT] = 1'b1;
                end
                send(r[13:12], src, dst, predict(r[13:12], dst));
            end
            drain();
        end
        check_counters(model_hits, model_floods);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all headers were answered");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int total;
        rst_n = 1'b0;
        hdr_valid_i = 1'b0;
        hdr_port_i = '0;
        hdr_src_i = '0;
        hdr_dst_i = '0;
        cfg_we_i = 1'b0;
        cfg_addr_i = '0;
        cfg_wdata_i = '0;
        test_reset_defaults();
        test_flood();
        test_learn_hit();
        test_station_move();
        test_disabled_ports();
        test_random_stream();
        total = mask_errors + count_errors + reg_errors + other_errors + uut.u_checker.failures;
        $display("Errors: mask %0d, counter %0d, register %0d, other %0d, assertion %0d",
                 mask_errors, count_errors, reg_errors, other_errors, uut.u_checker.failures);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/address_table.sv */
`timescale 1ns/100ps
`default_nettype none

module address_table #(
    parameter int NUM_PORTS = switch_pkg::NUM_PORTS
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,

    input  wire logic                         learn_req_i,
    input  wire logic [switch_pkg::MAC_W-1:0] learn_address_i,
    input  wire logic [$clog2(NUM_PORTS)-1:0] learn_port_i,

    input  wire logic                         read_req_i,
    input  wire logic [switch_pkg::MAC_W-1:0] read_address_i,

    output logic      [$clog2(NUM_PORTS)-1:0] read_port_o,
    output logic                              read_port_valid_o
);

    import switch_pkg::*;

    logic [MAC_W-1:0]             table_address [NUM_ENTRIES];
    logic [$clog2(NUM_PORTS)-1:0] table_port [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0]       table_used;
    logic [NUM_ENTRIES-1:0][HIT_W-1:0] table_hits;

    logic [NUM_ENTRIES-1:0]       learn_same_addr;
    logic [NUM_ENTRIES-1:0]       learn_same_pair;
    logic [NUM_ENTRIES-1:0]       read_hit;
    logic [$clog2(NUM_PORTS)-1:0] hit_port;
    logic [IDX_W-1:0]             next_index;
    logic                         write_new;

    // Only entries in use take part in any match.
    always_comb begin
        hit_port = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            learn_same_addr[i] = table_used[i] && (table_address[i] == learn_address_i);
            learn_same_pair[i] = learn_same_addr[i] && (table_port[i] == learn_port_i);
            read_hit[i] = table_used[i] && (table_address[i] == read_address_i);
            if (read_hit[i]) begin
                hit_port = table_port[i];
            end
        end
    end

    assign next_index = free_index(table_used, table_hits);
    assign write_new = learn_req_i && !(|learn_same_pair);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            table_used <= '0;
            table_hits <= '0;
            read_port_valid_o <= 1'b0;
        end else begin
            read_port_valid_o <= read_req_i && (|read_hit);

            // Station moved to another port.
            if (learn_req_i) begin
                for (int i = 0; i < NUM_ENTRIES; i++) begin
                    if (learn_same_addr[i] && !learn_same_pair[i]) begin
                        table_used[i] <= 1'b0;
                    end
                end
            end

            if (read_req_i) begin
                for (int i = 0; i < NUM_ENTRIES; i++) begin
                    if (!(write_new && next_index == IDX_W'(i))) begin
                        if (read_hit[i]) begin
                            if (table_hits[i] != HIT_W'(MAX_HIT - 1)) begin
                                table_hits[i] <= table_hits[i] + 1'b1;
                            end
                        end else if (table_hits[i] != '0) begin
                            table_hits[i] <= table_hits[i] - 1'b1;
                        end
                    end
                end
            end

            if (write_new) begin
                table_used[next_index] <= 1'b1;
                table_hits[next_index] <= HIT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_new) begin
            table_address[next_index] <= learn_address_i;
            table_port[next_index] <= learn_port_i;
        end
    end

    always_ff @(posedge clk) begin
        if (read_req_i) begin
            read_port_o <= hit_port;
        end
    end

endmodule

`default_nettype wire

/* design/forward_decision.sv */
`timescale 1ns/100ps
`default_nettype none

module forward_decision (
    input  wire logic                             clk,
    input  wire logic                             rst_n,

    input  wire logic                             hdr_valid_i,
    input  wire logic [switch_pkg::PORT_W-1:0]    hdr_port_i,
    input  wire logic [switch_pkg::MAC_W-1:0]     hdr_src_i,
    input  wire logic [switch_pkg::MAC_W-1:0]     hdr_dst_i,

    input  wire logic [switch_pkg::NUM_PORTS-1:0] port_en_i,
    input  wire logic                             learn_en_i,

    input  wire logic [switch_pkg::PORT_W-1:0]    read_port_i,
    input  wire logic                             read_port_valid_i,

    output logic                                  learn_req_o,
    output logic      [switch_pkg::MAC_W-1:0]     learn_address_o,
    output logic      [switch_pkg::PORT_W-1:0]    learn_port_o,

    output logic                                  read_req_o,
    output logic      [switch_pkg::MAC_W-1:0]     read_address_o,

    output logic                                  fwd_valid_o,
    output logic      [switch_pkg::NUM_PORTS-1:0] fwd_mask_o,
    output logic                                  hit_pulse_o,
    output logic                                  flood_pulse_o
);

    import switch_pkg::*;

    logic                 s1_valid;
    logic [PORT_W-1:0]    s1_port;
    logic                 s1_dst_group;
    logic [NUM_PORTS-1:0] s1_port_en;

    logic [NUM_PORTS-1:0] ingress_bit;
    logic [NUM_PORTS-1:0] egress_bit;
    logic [NUM_PORTS-1:0] next_mask;
    logic                 next_hit;
    logic                 next_flood;

    // Group sources are never learned.
    assign learn_req_o = hdr_valid_i && learn_en_i && port_en_i[hdr_port_i]
                         && !hdr_src_i[MAC_GROUP_BIT];
    assign learn_address_o = hdr_src_i;
    assign learn_port_o = hdr_port_i;

    assign read_req_o = hdr_valid_i;
    assign read_address_o = hdr_dst_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= hdr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        s1_port <= hdr_port_i;
        s1_dst_group <= hdr_dst_i[MAC_GROUP_BIT];
        s1_port_en <= port_en_i;
    end

    assign ingress_bit = {{(NUM_PORTS-1){1'b0}}, 1'b1} << s1_port;
    assign egress_bit = {{(NUM_PORTS-1){1'b0}}, 1'b1} << read_port_i;

    // Mask rule on the table result.
    always_comb begin
        next_mask = '0;
        next_hit = 1'b0;
        next_flood = 1'b0;
        if (s1_valid && s1_port_en[s1_port]) begin
            if (read_port_valid_i && !s1_dst_group) begin
                next_mask = egress_bit & s1_port_en & ~ingress_bit;
                next_hit = 1'b1;
            end else begin
                next_mask = s1_port_en & ~ingress_bit;
                next_flood = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fwd_valid_o <= 1'b0;
            fwd_mask_o <= '0;
            hit_pulse_o <= 1'b0;
            flood_pulse_o <= 1'b0;
        end else begin
            fwd_valid_o <= s1_valid;
            fwd_mask_o <= next_mask;
            hit_pulse_o <= next_hit;
            flood_pulse_o <= next_flood;
        end
    end

endmodule

`default_nettype wire

/* design/switch_cfg_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module switch_cfg_regs (
    input  wire logic                              clk,
    input  wire logic                              rst_n,

    input  wire logic                              cfg_we_i,
    input  wire logic [switch_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
    input  wire logic [switch_pkg::CFG_DATA_W-1:0] cfg_wdata_i,

    input  wire logic                              hit_pulse_i,
    input  wire logic                              flood_pulse_i,

    output logic      [switch_pkg::CFG_DATA_W-1:0] cfg_rdata_o,
    output logic      [switch_pkg::NUM_PORTS-1:0]  port_en_o,
    output logic                                   learn_en_o
);

    import switch_pkg::*;

    logic [CFG_DATA_W-1:0] hit_cnt;
    logic [CFG_DATA_W-1:0] flood_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            port_en_o <= '1;
            learn_en_o <= 1'b1;
        end else if (cfg_we_i) begin
            if (cfg_addr_i == REG_PORT_EN) begin
                port_en_o <= cfg_wdata_i[NUM_PORTS-1:0];
            end
            if (cfg_addr_i == REG_LEARN_EN) begin
                learn_en_o <= cfg_wdata_i[0];
            end
        end
    end

    // A write clears, and wins over a pulse in the same cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_cnt <= '0;
            flood_cnt <= '0;
        end else begin
            if (cfg_we_i && cfg_addr_i == REG_HIT_CNT) begin
                hit_cnt <= '0;
            end else if (hit_pulse_i) begin
                hit_cnt <= hit_cnt + 1'b1;
            end
            if (cfg_we_i && cfg_addr_i == REG_FLOOD_CNT) begin
                flood_cnt <= '0;
            end else if (flood_pulse_i) begin
                flood_cnt <= flood_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        cfg_rdata_o = '0;
        case (cfg_addr_i)
            REG_PORT_EN:   cfg_rdata_o[NUM_PORTS-1:0] = port_en_o;
            REG_LEARN_EN:  cfg_rdata_o[0] = learn_en_o;
            REG_HIT_CNT:   cfg_rdata_o = hit_cnt;
            REG_FLOOD_CNT: cfg_rdata_o = flood_cnt;
            default:       cfg_rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/switch_core.sv */
`timescale 1ns/100ps
`default_nettype none

module switch_core (
    input  wire logic                              clk,
    input  wire logic                              rst_n,

    input  wire logic                              hdr_valid_i,
    input  wire logic [switch_pkg::PORT_W-1:0]     hdr_port_i,
    input  wire logic [switch_pkg::MAC_W-1:0]      hdr_src_i,
    input  wire logic [switch_pkg::MAC_W-1:0]      hdr_dst_i,

    input  wire logic                              cfg_we_i,
    input  wire logic [switch_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
    input  wire logic [switch_pkg::CFG_DATA_W-1:0] cfg_wdata_i,
    output logic      [switch_pkg::CFG_DATA_W-1:0] cfg_rdata_o,

    output logic                                   fwd_valid_o,
    output logic      [switch_pkg::NUM_PORTS-1:0]  fwd_mask_o
);

    import switch_pkg::*;

    logic                 learn_req;
    logic [MAC_W-1:0]     learn_address;
    logic [PORT_W-1:0]    learn_port;
    logic                 read_req;
    logic [MAC_W-1:0]     read_address;
    logic [PORT_W-1:0]    read_port;
    logic                 read_port_valid;
    logic [NUM_PORTS-1:0] port_en;
    logic                 learn_en;
    logic                 hit_pulse;
    logic                 flood_pulse;

    forward_decision u_forward_decision (
        .clk               (clk),
        .rst_n             (rst_n),
        .hdr_valid_i       (hdr_valid_i),
        .hdr_port_i        (hdr_port_i),
        .hdr_src_i         (hdr_src_i),
        .hdr_dst_i         (hdr_dst_i),
        .port_en_i         (port_en),
        .learn_en_i        (learn_en),
        .read_port_i       (read_port),
        .read_port_valid_i (read_port_valid),
        .learn_req_o       (learn_req),
        .learn_address_o   (learn_address),
        .learn_port_o      (learn_port),
        .read_req_o        (read_req),
        .read_address_o    (read_address),
        .fwd_valid_o       (fwd_valid_o),
        .fwd_mask_o        (fwd_mask_o),
        .hit_pulse_o       (hit_pulse),
        .flood_pulse_o     (flood_pulse)
    );

    address_table #(
        .NUM_PORTS (NUM_PORTS)
    ) u_address_table (
        .clk               (clk),
        .rst_n             (rst_n),
        .learn_req_i       (learn_req),
        .learn_address_i   (learn_address),
        .learn_port_i      (learn_port),
        .read_req_i        (read_req),
        .read_address_i    (read_address),
        .read_port_o       (read_port),
        .read_port_valid_o (read_port_valid)
    );

    switch_cfg_regs u_switch_cfg_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_we_i      (cfg_we_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .hit_pulse_i   (hit_pulse),
        .flood_pulse_i (flood_pulse),
        .cfg_rdata_o   (cfg_rdata_o),
        .port_en_o     (port_en),
        .learn_en_o    (learn_en)
    );

endmodule

`default_nettype wire

/* design/switch_pkg.sv */
`default_nettype none

package switch_pkg;

    localparam int NUM_PORTS = 4;
    localparam int PORT_W = $clog2(NUM_PORTS);
    localparam int NUM_ENTRIES = 8;
    localparam int IDX_W = $clog2(NUM_ENTRIES);
    localparam int MAX_HIT = 8;
    localparam int HIT_W = $clog2(MAX_HIT);
    localparam int MAC_W = 48;
    // I/G bit is the first octet LSB on the wire.
    localparam int MAC_GROUP_BIT = 40;

    localparam int CFG_ADDR_W = 2;
    localparam int CFG_DATA_W = 32;

    localparam logic [CFG_ADDR_W-1:0] REG_PORT_EN = 2'd0;
    localparam logic [CFG_ADDR_W-1:0] REG_LEARN_EN = 2'd1;
    localparam logic [CFG_ADDR_W-1:0] REG_HIT_CNT = 2'd2;
    localparam logic [CFG_ADDR_W-1:0] REG_FLOOD_CNT = 2'd3;

    // First unused entry, else the lowest score with lowest index first.
    function automatic logic [IDX_W-1:0] free_index(
        input logic [NUM_ENTRIES-1:0] used,
        input logic [NUM_ENTRIES-1:0][HIT_W-1:0] hits
    );
        logic [IDX_W-1:0] idx;
        logic [HIT_W-1:0] best;
        logic found;
        idx = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!found && !used[i]) begin
                idx = IDX_W'(i);
                found = 1'b1;
            end
        end
        if (!found) begin
            best = hits[0];
            for (int i = 1; i < NUM_ENTRIES; i++) begin
                if (hits[i] < best) begin
                    best = hits[i];
                    idx = IDX_W'(i);
                end
            end
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

/* flist.f */
design/switch_pkg.sv
design/address_table.sv
design/forward_decision.sv
design/switch_cfg_regs.sv
design/switch_core.sv
bench/switch_core_checker.sv
bench/tb_switch_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator; the run passes only if the log holds the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_switch_core -f flist.f -o tb_switch_core \
    || { echo "Build failed"; exit 1; }
./obj_dir/tb_switch_core +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "^TEST RESULT: PASS$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
